// ==== src/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    // widths
    localparam int TIMER_W = 16;
    localparam int APB_AW  = 4;
    localparam int APB_DW  = 32;

    // interrupt bit positions in INT_EN and INT_STATUS
    localparam int INT_EXT_BIT = 0;
    localparam int INT_TMR_BIT = 1;

    // redirect count sits in the upper half of the idle state word
    localparam int IDLE_CNT_LSB = 16;

    // flags of the instruction at the ROB head
    typedef struct packed {
        logic is_branch;
        logic branch_taken;
        logic predicted_taken;
        logic is_excp;
        logic is_ertn;
        logic is_idle;
    } commit_info_t;

    typedef struct packed {
        logic ififo;
        logic prf;
        logic queue;
        logic dfifo;
        logic rob;
    } full_flags_t;

    // cache refill traffic on the shared bus
    typedef struct packed {
        logic if_req;
        logic mem_req;
    } bus_busy_t;

    typedef struct packed {
        logic branch;
        logic excp;
        logic ertn;
        logic idle;
    } redirect_t;

    // per-stage flush and stall lines, front end first
    typedef struct packed {
        logic stall_pc;
        logic flush_ifr;
        logic stall_ifr;
        logic flush_ififo;
        logic stall_ififo;
        logic flush_id;
        logic stall_id;
        logic flush_srat;
        logic stall_srat;
        logic flush_queue;
        logic stall_lsuq;
        logic flush_back;
        logic flush_lsu_out;
        logic stall_in;
        logic flush_rob;
    } pipe_ctrl_t;

    typedef enum logic {
        IDLE_RUN   = 1'b0,
        IDLE_SLEEP = 1'b1
    } idle_state_e;

    typedef enum logic [APB_AW-1:0] {
        CSR_INT_EN     = 4'h0,
        CSR_TMR_RELOAD = 4'h4,
        CSR_INT_STATUS = 4'h8,
        CSR_IDLE_STATE = 4'hC
    } csr_addr_e;

endpackage

// ==== src/hazard_ctrl.sv ====
module hazard_ctrl
    import pipe_ctrl_pkg::*;
(
    input  commit_info_t commit,
    input  full_flags_t  full,
    input  bus_busy_t    busy,
    input  logic         jump,
    input  logic         miss,
    input  logic         idle_lock,
    output redirect_t    redirect,
    output pipe_ctrl_t   ctrl
);

    logic any_redirect;
    logic back_full;

    // redirect causes straight from the ROB head
    always_comb begin
        redirect.branch = commit.is_branch &
                          (commit.branch_taken != commit.predicted_taken);
        redirect.excp   = commit.is_excp;
        redirect.ertn   = commit.is_ertn;
        redirect.idle   = commit.is_idle;
    end

    assign any_redirect = |redirect;

    // any of these blocks dispatch
    assign back_full = full.prf | full.queue | full.rob;

    always_comb begin
        // whole back end goes on a redirect
        ctrl.flush_back  = any_redirect;
        ctrl.flush_rob   = any_redirect;
        ctrl.flush_queue = any_redirect;
        ctrl.flush_srat  = any_redirect;
        ctrl.flush_id    = any_redirect;
        ctrl.flush_ififo = any_redirect;

        // front end held while the back end is full
        ctrl.stall_ififo = back_full;
        ctrl.stall_id    = back_full;
        ctrl.stall_srat  = back_full;
        ctrl.stall_in    = back_full;

        // load-store side
        ctrl.stall_lsuq    = full.dfifo | busy.mem_req;
        ctrl.flush_lsu_out = any_redirect | busy.mem_req;

        // fetch
        ctrl.stall_ifr = full.ififo;
        ctrl.stall_pc  = full.ififo | idle_lock | busy.if_req;
        ctrl.flush_ifr = any_redirect | idle_lock | jump | miss;
    end

endmodule

// ==== src/idle_fsm.sv ====
module idle_fsm
    import pipe_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        idle_commit,
    input  logic        has_int,
    output logic        idle_lock,
    output idle_state_e idle_state
);

    idle_state_e state;
    idle_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE_RUN: begin
                // an interrupt already pending means no sleep at all
                if (idle_commit && !has_int) begin
                    state_nxt = IDLE_SLEEP;
                end
            end
            IDLE_SLEEP: begin
                if (has_int) begin
                    state_nxt = IDLE_RUN;
                end
            end
            default: begin
                state_nxt = IDLE_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // pc held and fetch register cleared while asleep
    assign idle_lock  = (state == IDLE_SLEEP);
    assign idle_state = state;

endmodule

// ==== src/wake_timer.sv ====
module wake_timer
    import pipe_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               tmr_en,
    input  logic               tmr_load,
    input  logic [TIMER_W-1:0] tmr_reload,
    output logic               tick
);

    logic [TIMER_W-1:0] count;
    logic               at_zero;

    assign at_zero = (count == '0);

    // one pulse per period, only while counting
    assign tick = tmr_en & at_zero;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (tmr_load) begin
            count <= tmr_reload;
        end else if (tmr_en) begin
            // period is reload + 1
            if (at_zero) begin
                count <= tmr_reload;
            end else begin
                count <= count - TIMER_W'(1);
            end
        end
    end

endmodule

// ==== src/apb_csr.sv ====
module apb_csr
    import pipe_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [APB_AW-1:0]  paddr,
    input  logic [APB_DW-1:0]  pwdata,
    output logic [APB_DW-1:0]  prdata,
    output logic               pready,
    output logic               pslverr,

    input  logic               tick,
    input  logic               ext_int,
    input  redirect_t          redirect,
    input  idle_state_e        idle_state,

    output logic               tmr_en,
    output logic               tmr_load,
    output logic [TIMER_W-1:0] tmr_reload,
    output logic               has_int
);

    csr_addr_e          addr;
    logic               access;
    logic               addr_ok;
    logic               bad_wr;
    logic               err;
    logic               wr_en;
    logic [APB_DW-1:0]  rdata;
    logic [1:0]         int_en;
    logic               tmr_pend;
    logic [TIMER_W-1:0] redirect_cnt;

    assign addr   = csr_addr_e'(paddr);
    assign access = psel & penable;

    // read mux and address decode
    always_comb begin
        addr_ok = 1'b1;
        bad_wr  = 1'b0;
        rdata   = '0;
        case (addr)
            CSR_INT_EN: begin
                rdata[1:0] = int_en;
            end
            CSR_TMR_RELOAD: begin
                rdata[TIMER_W-1:0] = tmr_reload;
            end
            CSR_INT_STATUS: begin
                rdata[INT_EXT_BIT] = ext_int;
                rdata[INT_TMR_BIT] = tmr_pend;
            end
            CSR_IDLE_STATE: begin
                // read-only
                bad_wr = pwrite;
                rdata[0] = (idle_state == IDLE_SLEEP);
                rdata[IDLE_CNT_LSB +: TIMER_W] = redirect_cnt;
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    assign err     = !addr_ok || bad_wr;
    assign wr_en   = access & pwrite & ~err;
    assign pready  = 1'b1;
    assign pslverr = access & err;
    assign prdata  = (access && !pwrite) ? rdata : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            int_en       <= '0;
            tmr_reload   <= '0;
            tmr_load     <= 1'b0;
            tmr_pend     <= 1'b0;
            redirect_cnt <= '0;
        end else begin
            tmr_load <= wr_en && (addr == CSR_TMR_RELOAD);
            if (wr_en && addr == CSR_INT_EN) begin
                int_en <= pwdata[1:0];
            end
            if (wr_en && addr == CSR_TMR_RELOAD) begin
                tmr_reload <= pwdata[TIMER_W-1:0];
            end
            // a new tick wins over a clear in the same cycle
            if (tick) begin
                tmr_pend <= 1'b1;
            end else if (wr_en && addr == CSR_INT_STATUS && pwdata[INT_TMR_BIT]) begin
                tmr_pend <= 1'b0;
            end
            // wraps
            if (|redirect) begin
                redirect_cnt <= redirect_cnt + TIMER_W'(1);
            end
        end
    end

    assign tmr_en  = int_en[INT_TMR_BIT];
    assign has_int = (int_en[INT_EXT_BIT] & ext_int) |
                     (int_en[INT_TMR_BIT] & tmr_pend);

endmodule

// ==== src/pipe_ctrl_top.sv ====
module pipe_ctrl_top
    import pipe_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  commit_info_t      commit,
    input  full_flags_t       full,
    input  bus_busy_t         busy,
    input  logic              jump,
    input  logic              miss,
    input  logic              ext_int,

    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr,

    output pipe_ctrl_t        ctrl,
    output redirect_t         redirect,
    output logic              has_int
);

    logic               idle_lock;
    idle_state_e        idle_state;
    logic               tick;
    logic               tmr_en;
    logic               tmr_load;
    logic [TIMER_W-1:0] tmr_reload;

    hazard_ctrl u_hazard (
        .commit    (commit),
        .full      (full),
        .busy      (busy),
        .jump      (jump),
        .miss      (miss),
        .idle_lock (idle_lock),
        .redirect  (redirect),
        .ctrl      (ctrl)
    );

    idle_fsm u_idle (
        .clk         (clk),
        .rst         (rst),
        .idle_commit (redirect.idle),
        .has_int     (has_int),
        .idle_lock   (idle_lock),
        .idle_state  (idle_state)
    );

    wake_timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .tmr_en     (tmr_en),
        .tmr_load   (tmr_load),
        .tmr_reload (tmr_reload),
        .tick       (tick)
    );

    apb_csr u_csr (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .tick       (tick),
        .ext_int    (ext_int),
        .redirect   (redirect),
        .idle_state (idle_state),
        .tmr_en     (tmr_en),
        .tmr_load   (tmr_load),
        .tmr_reload (tmr_reload),
        .has_int    (has_int)
    );

endmodule

// ==== dv/clk_rst_gen.sv ====
module clk_rst_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 5;
    localparam int RST_CYCLES  = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // active low, released on the third rising edge
    initial begin
        rst = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// ==== dv/tb_pipe_ctrl.sv ====
module tb_pipe_ctrl
    import pipe_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // full sequence runs roughly 360 cycles
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_VECTORS = 200;
    localparam int WAKE_RELOAD    = 20;

    logic              clk;
    logic              rst;
    commit_info_t      commit;
    full_flags_t       full;
    bus_busy_t         busy;
    logic              jump;
    logic              miss;
    logic              ext_int;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    pipe_ctrl_t        ctrl;
    redirect_t         redirect;
    logic              has_int;

    // reference model
    redirect_t          exp_redir;
    pipe_ctrl_t         exp_ctrl;
    logic               redir_any;
    logic               exp_int;
    logic               exp_err;
    logic [APB_DW-1:0]  exp_rdata;
    logic               access;
    logic               wr_ok;
    logic [1:0]         m_int_en;
    logic [TIMER_W-1:0] m_reload;
    logic [TIMER_W-1:0] m_cnt;
    logic               m_load;
    logic               m_tick;
    logic               m_pend;
    logic               m_lock;
    logic [TIMER_W-1:0] m_redirects;

    int errors;
    int cycles;
    int wake_cycles;

    clk_rst_gen u_clk_rst (
        .clk (clk),
        .rst (rst)
    );

    pipe_ctrl_top dut (
        .clk      (clk),
        .rst      (rst),
        .commit   (commit),
        .full     (full),
        .busy     (busy),
        .jump     (jump),
        .miss     (miss),
        .ext_int  (ext_int),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .ctrl     (ctrl),
        .redirect (redirect),
        .has_int  (has_int)
    );

    assign access = psel & penable;
    assign wr_ok  = access & pwrite;
    assign m_tick = m_int_en[1] && (m_cnt == '0);
    assign exp_int = (m_int_en[0] & ext_int) | (m_int_en[1] & m_pend);

    always_comb begin
        exp_redir.branch = commit.is_branch && (commit.branch_taken ^ commit.predicted_taken);
        exp_redir.excp   = commit.is_excp;
        exp_redir.ertn   = commit.is_ertn;
        exp_redir.idle   = commit.is_idle;
        redir_any = exp_redir.branch || commit.is_excp || commit.is_ertn || commit.is_idle;
    end

    always_comb begin
        exp_ctrl = '0;
        if (redir_any) begin
            exp_ctrl.flush_back    = 1'b1;
            exp_ctrl.flush_rob     = 1'b1;
            exp_ctrl.flush_queue   = 1'b1;
            exp_ctrl.flush_srat    = 1'b1;
            exp_ctrl.flush_id      = 1'b1;
            exp_ctrl.flush_ififo   = 1'b1;
            exp_ctrl.flush_lsu_out = 1'b1;
            exp_ctrl.flush_ifr     = 1'b1;
        end
        if (full.prf || full.queue || full.rob) begin
            exp_ctrl.stall_ififo = 1'b1;
            exp_ctrl.stall_id    = 1'b1;
            exp_ctrl.stall_srat  = 1'b1;
            exp_ctrl.stall_in    = 1'b1;
        end
        if (full.dfifo || busy.mem_req) begin
            exp_ctrl.stall_lsuq = 1'b1;
        end
        if (busy.mem_req) begin
            exp_ctrl.flush_lsu_out = 1'b1;
        end
        if (full.ififo) begin
            exp_ctrl.stall_ifr = 1'b1;
            exp_ctrl.stall_pc  = 1'b1;
        end
        if (m_lock || busy.if_req) begin
            exp_ctrl.stall_pc = 1'b1;
        end
        if (m_lock || jump || miss) begin
            exp_ctrl.flush_ifr = 1'b1;
        end
    end

    always_comb begin
        exp_err   = 1'b0;
        exp_rdata = '0;
        case (paddr)
            CSR_INT_EN:     exp_rdata = {30'd0, m_int_en};
            CSR_TMR_RELOAD: exp_rdata = {16'd0, m_reload};
            CSR_INT_STATUS: exp_rdata = {30'd0, m_pend, ext_int};
            CSR_IDLE_STATE: begin
                exp_rdata = {m_redirects, 15'd0, m_lock};
                exp_err   = access && pwrite;
            end
            default:        exp_err = access;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            m_int_en    <= '0;
            m_reload    <= '0;
            m_load      <= 1'b0;
            m_cnt       <= '0;
            m_pend      <= 1'b0;
            m_lock      <= 1'b0;
            m_redirects <= '0;
        end else begin
            if (wr_ok && paddr == CSR_INT_EN) begin
                m_int_en <= pwdata[1:0];
            end
            if (wr_ok && paddr == CSR_TMR_RELOAD) begin
                m_reload <= pwdata[TIMER_W-1:0];
            end
            m_load <= wr_ok && (paddr == CSR_TMR_RELOAD);
            if (m_load || m_tick) begin
                m_cnt <= m_reload;
            end else if (m_int_en[1]) begin
                m_cnt <= m_cnt - 16'd1;
            end
            if (m_tick) begin
                m_pend <= 1'b1;
            end else if (wr_ok && paddr == CSR_INT_STATUS && pwdata[1]) begin
                m_pend <= 1'b0;
            end
            // sleep until any enabled interrupt
            if (m_lock) begin
                m_lock <= !exp_int;
            end else begin
                m_lock <= exp_redir.idle && !exp_int;
            end
            if (redir_any) begin
                m_redirects <= m_redirects + 16'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst) redirect == exp_redir)
        else begin
            errors++;
            $display("** Error %0t: redirect causes differ from the commit flags", $time);
        end

    assert property (@(posedge clk) disable iff (!rst) ctrl == exp_ctrl)
        else begin
            errors++;
            $display("** Error %0t: flush or stall lines differ from expected", $time);
        end

    assert property (@(posedge clk) disable iff (!rst) has_int == exp_int)
        else begin
            errors++;
            $display("** Error %0t: has_int differs from enabled sources", $time);
        end

    // a correctly predicted branch alone never flushes
    assert property (@(posedge clk) disable iff (!rst)
        (commit.is_branch && commit.branch_taken == commit.predicted_taken &&
         !commit.is_excp && !commit.is_ertn && !commit.is_idle)
        |-> (redirect == '0 && !ctrl.flush_back))
        else begin
            errors++;
            $display("** Error %0t: predicted branch caused a flush", $time);
        end

    assert property (@(posedge clk) disable iff (!rst)
        m_lock |-> (ctrl.stall_pc && ctrl.flush_ifr))
        else begin
            errors++;
            $display("** Error %0t: fetch not held while idle", $time);
        end

    assert property (@(posedge clk) disable iff (!rst) pready && pslverr == exp_err)
        else begin
            errors++;
            $display("** Error %0t: wrong APB pready or pslverr", $time);
        end

    assert property (@(posedge clk) disable iff (!rst)
        (access && !pwrite) |-> prdata == exp_rdata)
        else begin
            errors++;
            $display("** Error %0t: APB read data at 0x%h is wrong", $time, paddr);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic reg_access(input logic write, input logic [APB_AW-1:0] addr,
                              input logic [APB_DW-1:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic commit_idle();
        commit_info_t c;
        c = '0;
        c.is_idle = 1'b1;
        @(posedge clk);
        commit <= c;
        @(posedge clk);
        commit <= '0;
    endtask

    task automatic random_vectors(input int n);
        logic [31:0] rnd;
        repeat (n) begin
            @(posedge clk);
            rnd = $urandom;
            commit  <= rnd[5:0];
            full    <= rnd[10:6];
            busy    <= rnd[12:11];
            jump    <= rnd[13];
            miss    <= rnd[14];
            ext_int <= (rnd[16:15] == 2'b00);
        end
        // quiet inputs and one interrupt pulse to leave the core awake
        @(posedge clk);
        commit  <= '0;
        full    <= '0;
        busy    <= '0;
        jump    <= 1'b0;
        miss    <= 1'b0;
        ext_int <= 1'b1;
        @(posedge clk);
        ext_int <= 1'b0;
    endtask

    task automatic wait_timer_wake(output int n);
        n = 0;
        @(negedge clk);
        while (!has_int && n < 4 * WAKE_RELOAD) begin
            @(negedge clk);
            n++;
        end
    endtask

    initial begin
        commit  <= '0;
        full    <= '0;
        busy    <= '0;
        jump    <= 1'b0;
        miss    <= 1'b0;
        ext_int <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        void'($urandom(24));
        wait (rst === 1'b1);
        idle_cycles(2);

        // registers read back as zero
        reg_access(1'b0, CSR_INT_EN, '0);
        reg_access(1'b0, CSR_TMR_RELOAD, '0);
        reg_access(1'b0, CSR_INT_STATUS, '0);
        reg_access(1'b0, CSR_IDLE_STATE, '0);

        reg_access(1'b1, CSR_INT_EN, 32'h1);
        random_vectors(RANDOM_VECTORS);
        reg_access(1'b1, CSR_INT_EN, 32'h0);

        // idle lock, release by external line, then no lock with interrupt pending
        commit_idle();
        reg_access(1'b0, CSR_IDLE_STATE, '0);
        idle_cycles(2);
        reg_access(1'b1, CSR_INT_EN, 32'h1);
        @(posedge clk);
        ext_int <= 1'b1;
        idle_cycles(3);
        commit_idle();
        reg_access(1'b0, CSR_INT_STATUS, '0);
        @(posedge clk);
        ext_int <= 1'b0;
        idle_cycles(3);
        reg_access(1'b1, CSR_INT_EN, 32'h0);

        // register access and error responses
        reg_access(1'b1, CSR_TMR_RELOAD, 32'h0000_5a5a);
        reg_access(1'b0, CSR_TMR_RELOAD, '0);
        reg_access(1'b1, CSR_INT_EN, 32'h3);
        reg_access(1'b0, CSR_INT_EN, '0);
        reg_access(1'b1, CSR_INT_EN, 32'h0);
        reg_access(1'b0, 4'h2, '0);
        reg_access(1'b1, 4'h6, 32'hffff_ffff);
        reg_access(1'b1, CSR_IDLE_STATE, 32'hffff_ffff);
        reg_access(1'b0, CSR_INT_EN, '0);
        reg_access(1'b0, CSR_TMR_RELOAD, '0);
        reg_access(1'b0, CSR_INT_STATUS, '0);
        reg_access(1'b0, CSR_IDLE_STATE, '0);

        // timer wakes a sleeping core
        commit_idle();
        idle_cycles(2);
        reg_access(1'b1, CSR_INT_EN, 32'h2);
        reg_access(1'b1, CSR_TMR_RELOAD, WAKE_RELOAD);
        wait_timer_wake(wake_cycles);
        assert (wake_cycles <= WAKE_RELOAD + 2)
            else begin
                errors++;
                $display("** Error %0t: timer wake after %0d cycles", $time, wake_cycles);
            end
        reg_access(1'b0, CSR_INT_STATUS, '0);
        reg_access(1'b1, CSR_INT_STATUS, 32'h2);
        @(negedge clk);
        assert (!has_int)
            else begin
                errors++;
                $display("** Error %0t: has_int still high after pending clear", $time);
            end
        reg_access(1'b1, CSR_INT_EN, 32'h0);
        idle_cycles(3);

        $display("run complete: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/pipe_ctrl_pkg.sv
src/hazard_ctrl.sv
src/idle_fsm.sv
src/wake_timer.sv
src/apb_csr.sv
src/pipe_ctrl_top.sv
dv/clk_rst_gen.sv
dv/tb_pipe_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_pipe_ctrl -f filelist.f -o sim_pipe_ctrl \
    && ./obj_dir/sim_pipe_ctrl > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1
